// ==== src/axi_ram_config.svh ====
// bus and memory widths for the AXI RAM slave
// included by the package and the memory
`ifndef AXI_RAM_CONFIG_SVH
`define AXI_RAM_CONFIG_SVH

// AXI side
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 8

// memory side, 2^14 words of 4 bytes span the full 16-bit byte space
`define RAM_WORDS_LOG2 14
`define BYTE_OFFS_W 2

`endif

// ==== src/axi_ram_pkg.sv ====
// shared types for the AXI RAM slave
// import wildcard in module bodies, scoped names in port lists
package axi_ram_pkg;

`include "axi_ram_config.svh"

    typedef logic [`AXI_ADDR_W-1:0]     addr_t;
    typedef logic [`RAM_WORDS_LOG2-1:0] word_idx_t;

    typedef struct packed {
        word_idx_t              word;  // word index into the RAM
        logic [`BYTE_OFFS_W-1:0] offs;  // byte inside the word
    } word_addr_t;

    // one AXI byte address, seen flat or split
    typedef union packed {
        addr_t      flat;
        word_addr_t split;
    } axi_addr_u;

    typedef logic [`AXI_DATA_W-1:0]   data_t;
    typedef logic [`AXI_DATA_W/8-1:0] strb_t;
    typedef logic [`AXI_ID_W-1:0]     id_t;
    typedef logic [`AXI_LEN_W-1:0]    len_t;  // beats minus one

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11   // handled as INCR
    } burst_t;

    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY = 2'b00;

endpackage

// ==== src/ram_port_if.sv ====
// write and read port of the pseudo-dual-port RAM
// the write engine takes wr_side, the read engine rd_side, the memory mem
interface ram_port_if;
    import axi_ram_pkg::*;

    // write port
    logic      we;
    strb_t     wstrb;
    word_idx_t waddr;
    data_t     wdata;

    // read port, one cycle latency
    logic      re;
    word_idx_t raddr;
    data_t     rdata;  // held until the next re

    modport wr_side (
        output we, wstrb, waddr, wdata
    );

    modport rd_side (
        output re, raddr,
        input  rdata
    );

    modport mem (
        input  we, wstrb, waddr, wdata, re, raddr,
        output rdata
    );

endinterface

// ==== src/burst_addr_gen.sv ====
// beat counter and word address sequence of one AXI burst
// load on the address transfer, step once per beat
module burst_addr_gen (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  load,
    input  axi_ram_pkg::axi_addr_u start,
    input  axi_ram_pkg::len_t     len,
    input  axi_ram_pkg::burst_t   burst,
    input  logic                  step,
    output axi_ram_pkg::word_idx_t word_addr,
    output logic                  last
);
    import axi_ram_pkg::*;

    word_idx_t cur_word;
    word_idx_t wrap_mask;
    len_t      beat_cnt;
    len_t      len_r;
    burst_t    burst_r;

    // len+1 is a power of two for WRAP, so len itself masks the block
    assign wrap_mask = word_idx_t'(len_r);
    assign word_addr = cur_word;
    assign last      = (beat_cnt == len_r);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beat_cnt <= '0;
            len_r    <= '0;
            burst_r  <= BURST_INCR;
        end else if (load) begin
            beat_cnt <= '0;
            len_r    <= len;
            burst_r  <= burst;
        end else if (step) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (load) begin
            cur_word <= start.split.word;  // byte offset dropped, full-width beats
        end else if (step) begin
            case (burst_r)
                BURST_FIXED: cur_word <= cur_word;
                BURST_WRAP:  cur_word <= (cur_word & ~wrap_mask) |
                                         ((cur_word + 1'b1) & wrap_mask);
                default:     cur_word <= cur_word + 1'b1;  // INCR and reserved
            endcase
        end
    end

    wrap_len_legal: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        load && burst == BURST_WRAP |-> len inside {len_t'(1), len_t'(3), len_t'(7), len_t'(15)});

endmodule

// ==== src/axi_write_engine.sv ====
// AXI4 write channels, one burst at a time
// every accepted W beat goes straight to the RAM write port
module axi_write_engine (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    input  axi_ram_pkg::id_t    awid,
    input  axi_ram_pkg::addr_t  awaddr,
    input  axi_ram_pkg::len_t   awlen,
    input  axi_ram_pkg::burst_t awburst,
    input  logic                awvalid,
    output logic                awready,
    input  axi_ram_pkg::data_t  wdata,
    input  axi_ram_pkg::strb_t  wstrb,
    input  logic                wlast,
    input  logic                wvalid,
    output logic                wready,
    output axi_ram_pkg::id_t    bid,
    output axi_ram_pkg::resp_t  bresp,
    output logic                bvalid,
    input  logic                bready,
    ram_port_if.wr_side         ram
);
    import axi_ram_pkg::*;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    wr_state_t state;
    axi_addr_u aw_start;
    word_idx_t wr_word;
    logic      aw_hs;
    logic      w_hs;
    logic      beat_last;

    assign aw_start.flat = awaddr;
    assign aw_hs         = awvalid && awready;
    assign w_hs          = wvalid && wready;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = RESP_OKAY;

    burst_addr_gen addr_gen (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .load         (aw_hs),
        .start        (aw_start),
        .len          (awlen),
        .burst        (awburst),
        .step         (w_hs),
        .word_addr    (wr_word),
        .last         (beat_last)
    );

    // write at the edge of the W transfer
    assign ram.we    = w_hs;
    assign ram.wstrb = wstrb;
    assign ram.waddr = wr_word;
    assign ram.wdata = wdata;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_hs) state <= WR_DATA;
                end
                WR_DATA: begin
                    if (w_hs && beat_last) state <= WR_RESP;  // counted last beat
                end
                WR_RESP: begin
                    if (bready) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) bid <= awid;  // echoed on B
    end

    wlast_matches_count: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        w_hs |-> (wlast == beat_last));

endmodule

// ==== src/axi_read_engine.sv ====
// AXI4 read channels, one burst at a time
// RAM reads are issued only when the two-entry R buffer has room for them
module axi_read_engine (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    input  axi_ram_pkg::id_t    arid,
    input  axi_ram_pkg::addr_t  araddr,
    input  axi_ram_pkg::len_t   arlen,
    input  axi_ram_pkg::burst_t arburst,
    input  logic                arvalid,
    output logic                arready,
    output axi_ram_pkg::id_t    rid,
    output axi_ram_pkg::data_t  rdata,
    output axi_ram_pkg::resp_t  rresp,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,
    ram_port_if.rd_side         ram
);
    import axi_ram_pkg::*;

    typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_DRAIN} rd_state_t;

    rd_state_t  state;
    axi_addr_u  ar_start;
    word_idx_t  rd_word;
    logic       ar_hs;
    logic       r_hs;
    logic       beat_last;
    logic       issue;
    logic       pend;       // read issued last cycle, data on ram.rdata now
    logic       pend_last;
    data_t      ob_data [2];
    logic       ob_last [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] occ;
    logic [1:0] occ_after;

    assign ar_start.flat = araddr;
    assign ar_hs         = arvalid && arready;
    assign r_hs          = rvalid && rready;
    assign arready       = (state == RD_IDLE);

    // occupancy at the next edge, a read issued now lands one edge later
    assign occ_after = occ + {1'b0, pend} - {1'b0, r_hs};
    assign issue     = (state == RD_ISSUE) && !occ_after[1];

    burst_addr_gen addr_gen (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .load         (ar_hs),
        .start        (ar_start),
        .len          (arlen),
        .burst        (arburst),
        .step         (issue),
        .word_addr    (rd_word),
        .last         (beat_last)
    );

    assign ram.re    = issue;
    assign ram.raddr = rd_word;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state  <= RD_IDLE;
            pend   <= 1'b0;
            occ    <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            pend <= issue;
            occ  <= occ_after;
            if (pend) wr_ptr <= ~wr_ptr;
            if (r_hs) rd_ptr <= ~rd_ptr;
            case (state)
                RD_IDLE: begin
                    if (ar_hs) state <= RD_ISSUE;
                end
                RD_ISSUE: begin
                    if (issue && beat_last) state <= RD_DRAIN;  // all reads out
                end
                RD_DRAIN: begin
                    if (r_hs && rlast) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // payload side, no reset
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_hs) rid <= arid;
        if (issue) pend_last <= beat_last;
        if (pend) begin
            ob_data[wr_ptr] <= ram.rdata;
            ob_last[wr_ptr] <= pend_last;
        end
    end

    assign rvalid = (occ != 2'd0);
    assign rdata  = ob_data[rd_ptr];
    assign rlast  = ob_last[rd_ptr];
    assign rresp  = RESP_OKAY;

    r_hold_under_stall: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// ==== src/pd_ram.sv ====
// pseudo-dual-port word memory, byte strobes on write
// registered read, rdata holds until the next read
`include "axi_ram_config.svh"

module pd_ram (
    input logic      S_AXI_ACLK,
    input logic      S_AXI_ARESETN,
    ram_port_if.mem  port
);
    import axi_ram_pkg::*;

    localparam int NUM_BYTES = $bits(strb_t);

    data_t mem [0:(1 << `RAM_WORDS_LOG2) - 1];

    always_ff @(posedge S_AXI_ACLK) begin
        if (port.we) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (port.wstrb[b]) mem[port.waddr][8*b +: 8] <= port.wdata[8*b +: 8];
            end
        end
    end

    // same-word read and write in one cycle returns the old word
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            port.rdata <= '0;
        end else if (port.re) begin
            port.rdata <= mem[port.raddr];
        end
    end

endmodule

// ==== src/axi_ram_top.sv ====
// AXI4 slave with a byte-writable RAM behind it
// write and read engines each own one port of the memory
module axi_ram_top (
    input  logic                S_AXI_ACLK,
    input  logic                S_AXI_ARESETN,
    // AW
    input  axi_ram_pkg::id_t    awid,
    input  axi_ram_pkg::addr_t  awaddr,
    input  axi_ram_pkg::len_t   awlen,
    input  axi_ram_pkg::burst_t awburst,
    input  logic                awvalid,
    output logic                awready,
    // W
    input  axi_ram_pkg::data_t  wdata,
    input  axi_ram_pkg::strb_t  wstrb,
    input  logic                wlast,
    input  logic                wvalid,
    output logic                wready,
    // B
    output axi_ram_pkg::id_t    bid,
    output axi_ram_pkg::resp_t  bresp,
    output logic                bvalid,
    input  logic                bready,
    // AR
    input  axi_ram_pkg::id_t    arid,
    input  axi_ram_pkg::addr_t  araddr,
    input  axi_ram_pkg::len_t   arlen,
    input  axi_ram_pkg::burst_t arburst,
    input  logic                arvalid,
    output logic                arready,
    // R
    output axi_ram_pkg::id_t    rid,
    output axi_ram_pkg::data_t  rdata,
    output axi_ram_pkg::resp_t  rresp,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready
);

    ram_port_if ram_bus ();

    axi_write_engine wr_eng (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .ram(ram_bus.wr_side)
    );

    axi_read_engine rd_eng (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .ram(ram_bus.rd_side)
    );

    pd_ram ram (
        .S_AXI_ACLK,
        .S_AXI_ARESETN,
        .port(ram_bus.mem)
    );

endmodule

// ==== tests/tb_axi_ram.sv ====
// self-checking testbench for the AXI RAM slave
// the next address is offered while the previous response is still open
module tb_axi_ram;
    import axi_ram_pkg::*;

    typedef struct {
        bit     rd;
        addr_t  addr;
        len_t   len;
        burst_t burst;
        bit     part;  // random strobes on write
    } op_t;

    logic   S_AXI_ACLK = 1'b0;
    logic   S_AXI_ARESETN;
    id_t    awid, bid, arid, rid;
    addr_t  awaddr, araddr;
    len_t   awlen, arlen;
    burst_t awburst, arburst;
    data_t  wdata, rdata;
    strb_t  wstrb;
    resp_t  bresp, rresp;
    logic   awvalid, awready, wlast, wvalid, wready, bvalid, arvalid, arready, rlast, rvalid;
    logic   bready = 1'b0;
    logic   rready = 1'b0;

    data_t model [word_idx_t];  // expected RAM contents
    op_t   ops [$];
    id_t   exp_bid [$];
    id_t   exp_rid [$];
    data_t exp_rdata [$];
    logic  exp_rlast [$];
    logic  b_open = 1'b0;
    logic  r_open = 1'b0;
    logic  w_phase = 1'b0;  // between AW transfer and last W transfer
    int    cycle_cnt = 0;
    int    cycle_limit = 0;

    axi_ram_top uut (.*);

    always #50 S_AXI_ACLK = ~S_AXI_ACLK;

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_run("wrong data beat");
        end
    endtask

    task automatic check_id(string name, id_t got, id_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_run("ID not echoed");
        end
    endtask

    task automatic check_resp(string name, resp_t got, resp_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_run("wrong response code");
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            stop_run("wrong control bit");
        end
    endtask

    // expected word-aligned byte address of one beat
    function automatic addr_t beat_addr(addr_t start, len_t len, burst_t burst, int beat);
        int word;
        int beats;
        int base;
        word  = int'(start) >> 2;
        beats = int'(len) + 1;
        base  = word - (word % beats);  // wrap block aligned to its size
        case (burst)
            BURST_FIXED: return addr_t'(word * 4);
            BURST_WRAP:  return addr_t'((base + (word - base + beat) % beats) * 4);
            default:     return addr_t'((word + beat) * 4);  // INCR and reserved
        endcase
    endfunction

    task automatic queue_op(bit rd, addr_t addr, len_t len, burst_t burst, bit part);
        ops.push_back('{rd, addr, len, burst, part});
    endtask

    task automatic write_burst(op_t op);
        id_t       id;
        data_t     d;
        strb_t     s;
        word_idx_t w;
        data_t     merged;
        id = id_t'($urandom);
        while (exp_rdata.size() != 0) @(negedge S_AXI_ACLK);  // reads drained first
        @(posedge S_AXI_ACLK);
        awid    <= id;
        awaddr  <= op.addr;
        awlen   <= op.len;
        awburst <= op.burst;
        awvalid <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!awready);
        awvalid <= 1'b0;
        exp_bid.push_back(id);
        for (int i = 0; i <= int'(op.len); i++) begin
            d = $urandom;
            s = op.part ? strb_t'($urandom) : '1;
            wdata  <= d;
            wstrb  <= s;
            wlast  <= (i == int'(op.len));
            wvalid <= 1'b1;
            do @(posedge S_AXI_ACLK); while (!wready);
            w = word_idx_t'(beat_addr(op.addr, op.len, op.burst, i) >> 2);
            merged = model.exists(w) ? model[w] : 'x;
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (s[b]) merged[8*b +: 8] = d[8*b +: 8];
            end
            model[w] = merged;
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
    endtask

    task automatic read_burst(op_t op);
        id_t       id;
        word_idx_t w;
        id = id_t'($urandom);
        while (exp_bid.size() != 0) @(negedge S_AXI_ACLK);  // writes answered first
        @(posedge S_AXI_ACLK);
        arid    <= id;
        araddr  <= op.addr;
        arlen   <= op.len;
        arburst <= op.burst;
        arvalid <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!arready);
        arvalid <= 1'b0;
        for (int i = 0; i <= int'(op.len); i++) begin
            w = word_idx_t'(beat_addr(op.addr, op.len, op.burst, i) >> 2);
            exp_rdata.push_back(model[w]);
            exp_rid.push_back(id);
            exp_rlast.push_back(i == int'(op.len));
        end
    endtask

    // random back-pressure on B and R
    always @(posedge S_AXI_ACLK) begin
        bready <= ($urandom % 4) != 0;
        rready <= ($urandom % 4) != 0;
    end

    always @(posedge S_AXI_ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) stop_run("timeout: the bursts did not complete in time");
    end

    // sees the values present at the edge
    always @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARESETN) begin
            check_last("wready", wready, w_phase);
            if (awvalid && awready) begin
                if (b_open) stop_run("AW accepted before the previous B completed");
                b_open = 1'b1;
                w_phase = 1'b1;
            end
            if (wvalid && wready && wlast) w_phase = 1'b0;
            if (bvalid && bready) begin
                if (exp_bid.size() == 0) stop_run("B transfer with no write outstanding");
                check_id("bid", bid, exp_bid.pop_front());
                check_resp("bresp", bresp, RESP_OKAY);
                b_open = 1'b0;
            end
            if (arvalid && arready) begin
                if (r_open) stop_run("AR accepted before the previous read completed");
                r_open = 1'b1;
            end
            if (rvalid && rready) begin
                if (exp_rdata.size() == 0) stop_run("R transfer with no read beat expected");
                check_data("rdata", rdata, exp_rdata.pop_front());
                check_id("rid", rid, exp_rid.pop_front());
                check_resp("rresp", rresp, RESP_OKAY);
                check_last("rlast", rlast, exp_rlast.pop_front());
                if (rlast) r_open = 1'b0;
            end
        end
    end

    initial begin
        int    total_beats;
        addr_t a;
        len_t  l;
        void'($urandom(89));
        total_beats = 0;
        S_AXI_ARESETN <= 1'b0;
        {awid, arid} <= '0;
        {awaddr, araddr} <= '0;
        {awlen, arlen} <= '0;
        awburst <= BURST_INCR;
        arburst <= BURST_INCR;
        {wdata, wstrb} <= '0;
        {awvalid, wvalid, wlast, arvalid} <= '0;

        // INCR lengths, full strobes
        queue_op(1'b0, 16'h0100, 8'd0, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h0400, 8'd3, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h1000, 8'd15, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h2000, 8'd255, BURST_INCR, 1'b0);
        queue_op(1'b1, 16'h0100, 8'd0, BURST_INCR, 1'b0);
        queue_op(1'b1, 16'h0400, 8'd3, BURST_INCR, 1'b0);
        queue_op(1'b1, 16'h1000, 8'd15, BURST_INCR, 1'b0);
        queue_op(1'b1, 16'h2000, 8'd255, BURST_INCR, 1'b0);
        // partial strobes over known words
        queue_op(1'b0, 16'h3000, 8'd7, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h3000, 8'd7, BURST_INCR, 1'b1);
        queue_op(1'b1, 16'h3000, 8'd7, BURST_INCR, 1'b0);
        // FIXED merges into one word
        queue_op(1'b0, 16'h5000, 8'd0, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h5000, 8'd5, BURST_FIXED, 1'b1);
        queue_op(1'b1, 16'h5000, 8'd3, BURST_FIXED, 1'b0);
        // WRAP from mid-block
        queue_op(1'b0, 16'h6000, 8'd15, BURST_INCR, 1'b0);
        queue_op(1'b0, 16'h6008, 8'd3, BURST_WRAP, 1'b0);
        queue_op(1'b0, 16'h6014, 8'd7, BURST_WRAP, 1'b1);
        queue_op(1'b1, 16'h6008, 8'd3, BURST_WRAP, 1'b0);
        queue_op(1'b1, 16'h6014, 8'd7, BURST_WRAP, 1'b0);
        queue_op(1'b1, 16'h6000, 8'd15, BURST_INCR, 1'b0);
        // reserved type behaves as INCR
        queue_op(1'b0, 16'h7000, 8'd3, BURST_RSVD, 1'b0);
        queue_op(1'b1, 16'h7000, 8'd3, BURST_INCR, 1'b0);
        for (int k = 0; k < 6; k++) begin
            a = addr_t'(32'h8000 + ($urandom % 1024) * 4);
            l = len_t'($urandom % 32);
            queue_op(1'b0, a, l, BURST_INCR, 1'b0);
            queue_op(1'b1, a, l, BURST_INCR, 1'b0);
        end
        foreach (ops[i]) total_beats += int'(ops[i].len) + 1;
        cycle_limit = 20 * total_beats + 200;

        repeat (4) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge S_AXI_ACLK);
        check_last("bvalid", bvalid, 1'b0);
        check_last("rvalid", rvalid, 1'b0);
        check_last("awready", awready, 1'b1);
        check_last("arready", arready, 1'b1);

        foreach (ops[i]) begin
            if (ops[i].rd) read_burst(ops[i]);
            else write_burst(ops[i]);
        end
        while (exp_bid.size() != 0 || exp_rdata.size() != 0) @(negedge S_AXI_ACLK);
        @(posedge S_AXI_ACLK);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/axi_ram_pkg.sv
src/ram_port_if.sv
src/burst_addr_gen.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/pd_ram.sv
src/axi_ram_top.sv
tests/tb_axi_ram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_ram
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
